// File: common/tpl_adc_pkg.sv
// Transport ADC register map definitions
package tpl_adc_pkg;

  // Bus widths
  localparam int up_addr_width = 10;
  localparam int up_data_width = 32;
  localparam int axi_addr_width = 12;

  localparam logic [up_data_width-1:0] tpl_adc_version = 32'h000A0162;

  // ******************************************************************
  // Address map, all values in words
  // ******************************************************************
  localparam int blk_off_width = 8;
  localparam int chan_off_width = 4;
  localparam logic [up_addr_width-1:0] common_base = 10'h000;
  localparam logic [up_addr_width-1:0] channel_base = 10'h100;
  localparam logic [up_addr_width-1:0] channel_stride = 10'h010;
  localparam logic [up_addr_width-1:0] tpl_base = 10'h200;

  // Common block
  localparam logic [blk_off_width-1:0] reg_version = 8'h00;
  localparam logic [blk_off_width-1:0] reg_id = 8'h01;
  localparam logic [blk_off_width-1:0] reg_scratch = 8'h02;
  localparam logic [blk_off_width-1:0] reg_clk_ratio = 8'h16;
  localparam logic [blk_off_width-1:0] reg_status = 8'h17;
  localparam logic [blk_off_width-1:0] reg_chan_max = 8'h18;
  localparam logic [blk_off_width-1:0] reg_pn_summary = 8'h1A;
  localparam logic [blk_off_width-1:0] reg_ovf = 8'h21;

  // Channel block
  localparam logic [chan_off_width-1:0] reg_chan_ctrl = 4'h0;
  localparam logic [chan_off_width-1:0] reg_chan_status = 4'h1;
  localparam logic [chan_off_width-1:0] reg_chan_pn_sel = 4'h9;

  // Transport block
  localparam logic [blk_off_width-1:0] reg_profile_num = 8'h00;
  localparam logic [blk_off_width-1:0] reg_profile_sel = 8'h01;
  localparam logic [blk_off_width-1:0] reg_profile_base = 8'h10;

  // Field positions and widths
  localparam int chan_enable_bit = 0;
  localparam int chan_fmt_type_bit = 2;
  localparam int chan_fmt_enable_bit = 4;
  localparam int chan_sign_ext_bit = 6;
  localparam int stat_pn_err_bit = 1;
  localparam int stat_pn_oos_bit = 2;
  localparam int pn_sel_lsb = 16;
  localparam int pn_sel_width = 4;
  localparam int jesd_param_width = 8;

  localparam int up_timeout_cycles = 32;

  // True when addr lies in the window of size 2**off_width at base
  function automatic logic addr_hit(input logic [up_addr_width-1:0] addr,
                                    input logic [up_addr_width-1:0] base,
                                    input int off_width);
    return (addr >> off_width) == (base >> off_width);
  endfunction

endpackage

// File: common/up_bus_if.sv
// Register request bus
`timescale 1ns/1ps

interface up_bus_if import tpl_adc_pkg::*; ();

  logic                     wreq;
  logic [up_addr_width-1:0] waddr;
  logic [up_data_width-1:0] wdata;
  logic                     wack;
  logic                     rreq;
  logic [up_addr_width-1:0] raddr;
  logic [up_data_width-1:0] rdata;
  logic                     rack;

  // Bus master side
  modport requester (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rdata, rack
  );

  // Register block side
  modport responder (
    input  wreq, waddr, wdata, rreq, raddr,
    output wack, rdata, rack
  );

endinterface

// File: design/up_axi_slave.sv
// AXI4-Lite to register bus bridge
`timescale 1ns/1ps

module up_axi_slave import tpl_adc_pkg::*; (
  input  logic                      link_clk,
  input  logic                      adc_rst,
  input  logic                      awvalid,
  input  logic [axi_addr_width-1:0] awaddr,
  output logic                      awready,
  input  logic                      wvalid,
  input  logic [up_data_width-1:0]  wdata,
  output logic                      wready,
  output logic                      bvalid,
  output logic [1:0]                bresp,
  input  logic                      bready,
  input  logic                      arvalid,
  input  logic [axi_addr_width-1:0] araddr,
  output logic                      arready,
  output logic                      rvalid,
  output logic [1:0]                rresp,
  output logic [up_data_width-1:0]  rdata,
  input  logic                      rready,
  up_bus_if.requester               bus
);

  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_req = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;
  localparam logic [1:0] st_resp = 2'd3;
  localparam int cnt_width = $clog2(up_timeout_cycles + 1);

  logic [1:0]           state;
  logic                 is_write;
  logic [cnt_width-1:0] timeout_cnt;
  logic                 take_write;
  logic                 take_read;
  logic                 acked;
  logic                 timed_out;

  // Writes win, unless the previous transfer was also a write
  assign take_write = awvalid && wvalid && !(arvalid && is_write);
  assign take_read = arvalid && !take_write;

  assign acked = is_write ? bus.wack : bus.rack;
  assign timed_out = timeout_cnt == cnt_width'(up_timeout_cycles - 1);

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // ******************************************************************
  // Transfer FSM
  // ******************************************************************
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      state <= st_idle;
      awready <= 1'b0;
      wready <= 1'b0;
      arready <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      bus.wreq <= 1'b0;
      bus.rreq <= 1'b0;
      is_write <= 1'b0;
      timeout_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (take_write) begin
            awready <= 1'b1;
            wready <= 1'b1;
            is_write <= 1'b1;
            state <= st_req;
          end else if (take_read) begin
            arready <= 1'b1;
            is_write <= 1'b0;
            state <= st_req;
          end
        end
        st_req: begin
          // Handshake cycle, the request pulse follows
          awready <= 1'b0;
          wready <= 1'b0;
          arready <= 1'b0;
          bus.wreq <= is_write;
          bus.rreq <= !is_write;
          timeout_cnt <= '0;
          state <= st_wait;
        end
        st_wait: begin
          bus.wreq <= 1'b0;
          bus.rreq <= 1'b0;
          timeout_cnt <= timeout_cnt + 1'b1;
          if (acked || timed_out) begin
            bvalid <= is_write;
            rvalid <= !is_write;
            state <= st_resp;
          end
        end
        default: begin
          if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  // Address, write data and read data capture
  always_ff @(posedge link_clk) begin
    if (state == st_idle && take_write) begin
      bus.waddr <= awaddr[axi_addr_width-1:2];
      bus.wdata <= wdata;
    end
    if (state == st_idle && take_read) begin
      bus.raddr <= araddr[axi_addr_width-1:2];
    end
    // Zero on timeout
    if (state == st_wait) begin
      rdata <= bus.rack ? bus.rdata : '0;
    end
  end

  property p_valid_held(valid, ready);
    @(posedge link_clk) disable iff (adc_rst) valid && !ready |=> valid;
  endproperty

  a_bvalid_held: assert property (p_valid_held(bvalid, bready));
  a_rvalid_held: assert property (p_valid_held(rvalid, rready));

endmodule

// File: regmap/up_adc_common.sv
// ADC common register block
`timescale 1ns/1ps

module up_adc_common import tpl_adc_pkg::*; #(
  parameter logic [7:0] id = 8'd0,
  parameter int num_channels = 1,
  parameter int data_path_width = 1
) (
  input  logic         link_clk,
  input  logic         adc_rst,
  input  logic         adc_dovf,
  input  logic         pn_err_any,
  input  logic         pn_oos_any,
  up_bus_if.responder  bus
);

  logic                     wsel;
  logic                     rsel;
  logic [blk_off_width-1:0] woff;
  logic [blk_off_width-1:0] roff;
  logic                     adc_status;
  logic                     ovf_sticky;
  logic [up_data_width-1:0] scratch;
  logic [up_data_width-1:0] rd_word;

  // Address decode
  assign wsel = bus.wreq && addr_hit(bus.waddr, common_base, blk_off_width);
  assign rsel = bus.rreq && addr_hit(bus.raddr, common_base, blk_off_width);
  assign woff = bus.waddr[blk_off_width-1:0];
  assign roff = bus.raddr[blk_off_width-1:0];

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      bus.wack <= 1'b0;
      bus.rack <= 1'b0;
      adc_status <= 1'b0;
      ovf_sticky <= 1'b0;
      scratch <= '0;
    end else begin
      bus.wack <= wsel;
      bus.rack <= rsel;
      // Rises once reset is released
      adc_status <= 1'b1;
      if (wsel && woff == reg_scratch) begin
        scratch <= bus.wdata;
      end
      // Overflow wins over a clear in the same cycle
      if (adc_dovf) begin
        ovf_sticky <= 1'b1;
      end else if (wsel && woff == reg_ovf && bus.wdata[0]) begin
        ovf_sticky <= 1'b0;
      end
    end
  end

  // ******************************************************************
  // Read mux
  // ******************************************************************
  always_comb begin
    rd_word = '0;
    case (roff)
      reg_version: rd_word = tpl_adc_version;
      reg_id: rd_word = {24'd0, id};
      reg_scratch: rd_word = scratch;
      reg_clk_ratio: rd_word = up_data_width'(data_path_width);
      reg_status: rd_word[0] = adc_status;
      reg_chan_max: rd_word = up_data_width'(num_channels);
      reg_ovf: rd_word[0] = ovf_sticky;
      reg_pn_summary: rd_word[1:0] = {pn_err_any, pn_oos_any};
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    bus.rdata <= rsel ? rd_word : '0;
  end

endmodule

// File: regmap/up_adc_channel.sv
// ADC channel register block
`timescale 1ns/1ps

module up_adc_channel import tpl_adc_pkg::*; #(
  parameter int channel_index = 0
) (
  input  logic                    link_clk,
  input  logic                    adc_rst,
  input  logic                    pn_err,
  input  logic                    pn_oos,
  output logic                    enable,
  output logic                    dfmt_enable,
  output logic                    dfmt_sign_extend,
  output logic                    dfmt_type,
  output logic [pn_sel_width-1:0] pn_seq_sel,
  output logic                    status_pn_err,
  output logic                    status_pn_oos,
  up_bus_if.responder             bus
);

  // Window start of this channel
  localparam logic [up_addr_width-1:0] win_base =
    channel_base + up_addr_width'(channel_index) * channel_stride;

  logic                      wsel;
  logic                      rsel;
  logic [chan_off_width-1:0] woff;
  logic [chan_off_width-1:0] roff;
  logic [up_data_width-1:0]  rd_word;

  assign wsel = bus.wreq && addr_hit(bus.waddr, win_base, chan_off_width);
  assign rsel = bus.rreq && addr_hit(bus.raddr, win_base, chan_off_width);
  assign woff = bus.waddr[chan_off_width-1:0];
  assign roff = bus.raddr[chan_off_width-1:0];

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      bus.wack <= 1'b0;
      bus.rack <= 1'b0;
      enable <= 1'b0;
      dfmt_enable <= 1'b0;
      dfmt_sign_extend <= 1'b0;
      dfmt_type <= 1'b0;
      pn_seq_sel <= '0;
      status_pn_err <= 1'b0;
      status_pn_oos <= 1'b0;
    end else begin
      bus.wack <= wsel;
      bus.rack <= rsel;
      if (wsel && woff == reg_chan_ctrl) begin
        enable <= bus.wdata[chan_enable_bit];
        dfmt_type <= bus.wdata[chan_fmt_type_bit];
        dfmt_enable <= bus.wdata[chan_fmt_enable_bit];
        dfmt_sign_extend <= bus.wdata[chan_sign_ext_bit];
      end
      if (wsel && woff == reg_chan_pn_sel) begin
        pn_seq_sel <= bus.wdata[pn_sel_lsb +: pn_sel_width];
      end
      // Sticky PN flags, write 1 to clear
      if (pn_err) begin
        status_pn_err <= 1'b1;
      end else if (wsel && woff == reg_chan_status && bus.wdata[stat_pn_err_bit]) begin
        status_pn_err <= 1'b0;
      end
      if (pn_oos) begin
        status_pn_oos <= 1'b1;
      end else if (wsel && woff == reg_chan_status && bus.wdata[stat_pn_oos_bit]) begin
        status_pn_oos <= 1'b0;
      end
    end
  end

  always_comb begin
    rd_word = '0;
    case (roff)
      reg_chan_ctrl: begin
        rd_word[chan_enable_bit] = enable;
        rd_word[chan_fmt_type_bit] = dfmt_type;
        rd_word[chan_fmt_enable_bit] = dfmt_enable;
        rd_word[chan_sign_ext_bit] = dfmt_sign_extend;
      end
      reg_chan_status: begin
        rd_word[stat_pn_err_bit] = status_pn_err;
        rd_word[stat_pn_oos_bit] = status_pn_oos;
      end
      reg_chan_pn_sel: rd_word[pn_sel_lsb +: pn_sel_width] = pn_seq_sel;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge link_clk) begin
    bus.rdata <= rsel ? rd_word : '0;
  end

  // Each ack answers a one-cycle request from the cycle before
  a_ack_after_req: assert property (@(posedge link_clk) disable iff (adc_rst)
    (bus.wack || bus.rack) |->
      $past(bus.wreq || bus.rreq) && !$past(bus.wack || bus.rack));

endmodule

// File: regmap/up_tpl_common.sv
// Transport layer register block
`timescale 1ns/1ps

module up_tpl_common import tpl_adc_pkg::*; #(
  parameter int num_profiles = 1
) (
  input  logic                                     link_clk,
  input  logic                                     adc_rst,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_m,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_l,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_s,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_f,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_n,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_np,
  output logic [$clog2(num_profiles):0]            profile_sel,
  up_bus_if.responder                              bus
);

  localparam int sel_width = $clog2(num_profiles) + 1;
  localparam int w = jesd_param_width;

  logic                     wsel;
  logic                     rsel;
  logic [blk_off_width-1:0] woff;
  logic [blk_off_width-1:0] roff;
  logic [up_data_width-1:0] rd_word;

  assign wsel = bus.wreq && addr_hit(bus.waddr, tpl_base, blk_off_width);
  assign rsel = bus.rreq && addr_hit(bus.raddr, tpl_base, blk_off_width);
  assign woff = bus.waddr[blk_off_width-1:0];
  assign roff = bus.raddr[blk_off_width-1:0];

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      bus.wack <= 1'b0;
      bus.rack <= 1'b0;
      profile_sel <= '0;
    end else begin
      bus.wack <= wsel;
      bus.rack <= rsel;
      // Out of range selects are ignored
      if (wsel && woff == reg_profile_sel &&
          bus.wdata < up_data_width'(num_profiles)) begin
        profile_sel <= bus.wdata[sel_width-1:0];
      end
    end
  end

  // Two words per profile above reg_profile_base
  always_comb begin
    rd_word = '0;
    if (roff == reg_profile_num) begin
      rd_word = up_data_width'(num_profiles);
    end
    if (roff == reg_profile_sel) begin
      rd_word[sel_width-1:0] = profile_sel;
    end
    for (int p = 0; p < num_profiles; p++) begin
      if (roff == reg_profile_base + blk_off_width'(2 * p)) begin
        rd_word = {jesd_f[p*w +: w], jesd_s[p*w +: w], jesd_l[p*w +: w], jesd_m[p*w +: w]};
      end
      if (roff == reg_profile_base + blk_off_width'(2 * p + 1)) begin
        rd_word = {16'd0, jesd_np[p*w +: w], jesd_n[p*w +: w]};
      end
    end
  end

  always_ff @(posedge link_clk) begin
    bus.rdata <= rsel ? rd_word : '0;
  end

endmodule

// File: regmap/tpl_adc_regmap.sv
// Transport ADC register map top
`timescale 1ns/1ps

module tpl_adc_regmap import tpl_adc_pkg::*; #(
  parameter logic [7:0] id = 8'd0,
  parameter int num_channels = 1,
  parameter int num_profiles = 1,
  parameter int data_path_width = 1
) (
  input  logic                                     link_clk,
  input  logic                                     adc_rst,
  // AXI4-Lite
  input  logic                                     awvalid,
  input  logic [axi_addr_width-1:0]                awaddr,
  output logic                                     awready,
  input  logic                                     wvalid,
  input  logic [up_data_width-1:0]                 wdata,
  output logic                                     wready,
  output logic                                     bvalid,
  output logic [1:0]                               bresp,
  input  logic                                     bready,
  input  logic                                     arvalid,
  input  logic [axi_addr_width-1:0]                araddr,
  output logic                                     arready,
  output logic                                     rvalid,
  output logic [1:0]                               rresp,
  output logic [up_data_width-1:0]                 rdata,
  input  logic                                     rready,
  // Core side
  input  logic [num_channels-1:0]                  pn_err,
  input  logic [num_channels-1:0]                  pn_oos,
  input  logic                                     adc_dovf,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_m,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_l,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_s,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_f,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_n,
  input  logic [num_profiles*jesd_param_width-1:0] jesd_np,
  output logic [num_channels-1:0]                  enable,
  output logic [num_channels-1:0]                  dfmt_enable,
  output logic [num_channels-1:0]                  dfmt_sign_extend,
  output logic [num_channels-1:0]                  dfmt_type,
  output logic [num_channels*pn_sel_width-1:0]     pn_seq_sel,
  output logic [$clog2(num_profiles):0]            profile_sel
);

  // Block 0 is common, then the channels, transport last
  localparam int num_blocks = num_channels + 2;

  logic [num_blocks-1:0]    wack_s;
  logic [num_blocks-1:0]    rack_s;
  logic [up_data_width-1:0] rdata_s [num_blocks];
  logic [up_data_width-1:0] rdata_all;
  logic [num_channels-1:0]  status_pn_err_s;
  logic [num_channels-1:0]  status_pn_oos_s;

  up_bus_if bus_up ();
  up_bus_if bus_blk [num_blocks] ();

  up_axi_slave i_up_axi_slave (
    .link_clk, .adc_rst,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
    .bvalid, .bresp, .bready,
    .arvalid, .araddr, .arready,
    .rvalid, .rresp, .rdata, .rready,
    .bus (bus_up)
  );

  // ******************************************************************
  // Request fan-out and response merge
  // ******************************************************************
  for (genvar k = 0; k < num_blocks; k++) begin : g_fanout
    assign bus_blk[k].wreq = bus_up.wreq;
    assign bus_blk[k].waddr = bus_up.waddr;
    assign bus_blk[k].wdata = bus_up.wdata;
    assign bus_blk[k].rreq = bus_up.rreq;
    assign bus_blk[k].raddr = bus_up.raddr;
    assign wack_s[k] = bus_blk[k].wack;
    assign rack_s[k] = bus_blk[k].rack;
    assign rdata_s[k] = bus_blk[k].rdata;
  end

  always_comb begin
    rdata_all = '0;
    for (int k = 0; k < num_blocks; k++) begin
      rdata_all = rdata_all | rdata_s[k];
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      bus_up.wack <= 1'b0;
      bus_up.rack <= 1'b0;
    end else begin
      bus_up.wack <= |wack_s;
      bus_up.rack <= |rack_s;
    end
  end

  always_ff @(posedge link_clk) begin
    bus_up.rdata <= rdata_all;
  end

  // ******************************************************************
  // Register blocks
  // ******************************************************************
  up_adc_common #(
    .id (id),
    .num_channels (num_channels),
    .data_path_width (data_path_width)
  ) i_up_adc_common (
    .link_clk, .adc_rst, .adc_dovf,
    .pn_err_any (|status_pn_err_s),
    .pn_oos_any (|status_pn_oos_s),
    .bus (bus_blk[0])
  );

  for (genvar i = 0; i < num_channels; i++) begin : g_channel
    up_adc_channel #(
      .channel_index (i)
    ) i_up_adc_channel (
      .link_clk, .adc_rst,
      .pn_err (pn_err[i]),
      .pn_oos (pn_oos[i]),
      .enable (enable[i]),
      .dfmt_enable (dfmt_enable[i]),
      .dfmt_sign_extend (dfmt_sign_extend[i]),
      .dfmt_type (dfmt_type[i]),
      .pn_seq_sel (pn_seq_sel[i*pn_sel_width +: pn_sel_width]),
      .status_pn_err (status_pn_err_s[i]),
      .status_pn_oos (status_pn_oos_s[i]),
      .bus (bus_blk[i+1])
    );
  end

  up_tpl_common #(
    .num_profiles (num_profiles)
  ) i_up_tpl_common (
    .link_clk, .adc_rst,
    .jesd_m, .jesd_l, .jesd_s, .jesd_f, .jesd_n, .jesd_np,
    .profile_sel,
    .bus (bus_blk[num_blocks-1])
  );

  // Address windows must not overlap
  a_single_ack: assert property (@(posedge link_clk) disable iff (adc_rst)
    $onehot0({wack_s, rack_s}));

endmodule

// File: test/axi_lite_tasks.svh
// AXI4-Lite master tasks
`ifndef AXI_LITE_TASKS_SVH
`define AXI_LITE_TASKS_SVH

// Limits in link_clk cycles
localparam int hs_timeout = 16;
localparam int resp_timeout = up_timeout_cycles + 16;

// One write, address and data offered together
task automatic axi_lite_write(input logic [axi_addr_width-1:0] addr,
                              input logic [up_data_width-1:0] data);
  int cnt;
  @(posedge link_clk);
  awvalid <= 1'b1;
  awaddr <= addr;
  wvalid <= 1'b1;
  wdata <= data;
  cnt = 0;
  do begin
    @(posedge link_clk);
    cnt++;
  end while (!(awready && wready) && cnt < hs_timeout);
  awvalid <= 1'b0;
  wvalid <= 1'b0;
  if (!(awready && wready)) begin
    errors++;
    $display("Write to 0x%03h was not accepted within %0d cycles", addr, hs_timeout);
    return;
  end
  // Response phase
  bready <= 1'b1;
  cnt = 0;
  do begin
    @(posedge link_clk);
    cnt++;
  end while (!bvalid && cnt < resp_timeout);
  bready <= 1'b0;
  last_resp = bresp;
  if (!bvalid) begin
    errors++;
    $display("Write to 0x%03h got no response within %0d cycles", addr, resp_timeout);
  end
endtask

// One read, data returned through rd
task automatic axi_lite_read(input logic [axi_addr_width-1:0] addr,
                             output logic [up_data_width-1:0] rd);
  int cnt;
  rd = 'x;
  @(posedge link_clk);
  arvalid <= 1'b1;
  araddr <= addr;
  cnt = 0;
  do begin
    @(posedge link_clk);
    cnt++;
  end while (!arready && cnt < hs_timeout);
  arvalid <= 1'b0;
  if (!arready) begin
    errors++;
    $display("Read of 0x%03h was not accepted within %0d cycles", addr, hs_timeout);
    return;
  end
  rready <= 1'b1;
  cnt = 0;
  do begin
    @(posedge link_clk);
    cnt++;
  end while (!rvalid && cnt < resp_timeout);
  rready <= 1'b0;
  if (!rvalid) begin
    errors++;
    $display("Read of 0x%03h got no data within %0d cycles", addr, resp_timeout);
    return;
  end
  rd = rdata;
  last_resp = rresp;
endtask

`endif

// File: test/tb_tpl_adc_regmap.sv
// Register map testbench
`timescale 1ns/1ps

module tb_tpl_adc_regmap import tpl_adc_pkg::*; ();

  localparam int n_ch = 4;
  localparam int n_prof = 2;

  logic                        link_clk;
  logic                        adc_rst;
  logic                        awvalid;
  logic [axi_addr_width-1:0]   awaddr;
  logic                        awready;
  logic                        wvalid;
  logic [up_data_width-1:0]    wdata;
  logic                        wready;
  logic                        bvalid;
  logic [1:0]                  bresp;
  logic                        bready;
  logic                        arvalid;
  logic [axi_addr_width-1:0]   araddr;
  logic                        arready;
  logic                        rvalid;
  logic [1:0]                  rresp;
  logic [up_data_width-1:0]    rdata;
  logic                        rready;
  logic [n_ch-1:0]             pn_err;
  logic [n_ch-1:0]             pn_oos;
  logic                        adc_dovf;
  logic [n_prof*8-1:0]         jesd_m;
  logic [n_prof*8-1:0]         jesd_l;
  logic [n_prof*8-1:0]         jesd_s;
  logic [n_prof*8-1:0]         jesd_f;
  logic [n_prof*8-1:0]         jesd_n;
  logic [n_prof*8-1:0]         jesd_np;
  logic [n_ch-1:0]             enable;
  logic [n_ch-1:0]             dfmt_enable;
  logic [n_ch-1:0]             dfmt_sign_extend;
  logic [n_ch-1:0]             dfmt_type;
  logic [n_ch*4-1:0]           pn_seq_sel;
  logic [1:0]                  profile_sel;

  int         errors;
  int         checks;
  int         seed;
  logic [1:0] last_resp;

  `include "axi_lite_tasks.svh"

  tpl_adc_regmap #(
    .id (8'd7),
    .num_channels (n_ch),
    .num_profiles (n_prof),
    .data_path_width (4)
  ) dut0 (
    .link_clk, .adc_rst,
    .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
    .bvalid, .bresp, .bready, .arvalid, .araddr, .arready,
    .rvalid, .rresp, .rdata, .rready,
    .pn_err, .pn_oos, .adc_dovf,
    .jesd_m, .jesd_l, .jesd_s, .jesd_f, .jesd_n, .jesd_np,
    .enable, .dfmt_enable, .dfmt_sign_extend, .dfmt_type,
    .pn_seq_sel, .profile_sel
  );

  initial begin
    link_clk = 1'b0;
    forever #50 link_clk = ~link_clk;
  end

  function automatic logic [axi_addr_width-1:0] word_to_byte(input logic [9:0] word);
    return {word, 2'b00};
  endfunction

  // Channel window is 0x100 + 0x10 per channel
  function automatic logic [9:0] chan_word(input int ch, input logic [3:0] off);
    return 10'h100 + 10'(ch) * 10'h010 + 10'(off);
  endfunction

  task automatic check_read(input logic [9:0] word, input logic [31:0] exp,
                            input string what);
    logic [31:0] got;
    axi_lite_read(word_to_byte(word), got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s at word 0x%03h read 0x%08h, expected 0x%08h",
               $time, what, word, got, exp);
    end
  endtask

  // ******************************************************************
  // Directed tests
  // ******************************************************************
  task automatic reset_and_identity();
    @(posedge link_clk);
    checks++;
    if (enable !== '0 || dfmt_enable !== '0 || dfmt_sign_extend !== '0 ||
        dfmt_type !== '0 || pn_seq_sel !== '0 || profile_sel !== '0) begin
      errors++;
      $display("[ERROR] %0t: control outputs not zero after reset", $time);
    end
    check_read(10'h000, 32'h000A0162, "version");
    check_read(10'h001, 32'd7, "instance id");
    check_read(10'h016, 32'd4, "clock ratio");
    check_read(10'h018, 32'd4, "channel count");
  endtask

  task automatic scratch_readback();
    logic [31:0] val;
    for (int i = 0; i < 4; i++) begin
      val = $random(seed);
      axi_lite_write(word_to_byte(10'h002), val);
      check_read(10'h002, val, "scratch");
    end
  endtask

  task automatic channel_control();
    logic [31:0]       ctrl;
    logic [3:0]        pn;
    logic [n_ch-1:0]   exp_en;
    logic [n_ch-1:0]   exp_fe;
    logic [n_ch-1:0]   exp_se;
    logic [n_ch-1:0]   exp_ty;
    logic [n_ch*4-1:0] exp_pn;
    exp_en = '0;
    exp_fe = '0;
    exp_se = '0;
    exp_ty = '0;
    exp_pn = '0;
    for (int ch = 0; ch < n_ch; ch++) begin
      ctrl = $random(seed);
      pn = $random(seed);
      axi_lite_write(word_to_byte(chan_word(ch, 4'h0)), ctrl);
      axi_lite_write(word_to_byte(chan_word(ch, 4'h9)), {12'd0, pn, 16'd0});
      exp_en[ch] = ctrl[0];
      exp_ty[ch] = ctrl[2];
      exp_fe[ch] = ctrl[4];
      exp_se[ch] = ctrl[6];
      exp_pn[ch*4 +: 4] = pn;
      checks++;
      if (enable !== exp_en || dfmt_type !== exp_ty || dfmt_enable !== exp_fe ||
          dfmt_sign_extend !== exp_se || pn_seq_sel !== exp_pn) begin
        errors++;
        $display("[ERROR] %0t: channel %0d control outputs wrong", $time, ch);
      end
      check_read(chan_word(ch, 4'h0),
                 {25'd0, ctrl[6], 1'b0, ctrl[4], 1'b0, ctrl[2], 1'b0, ctrl[0]},
                 "channel control");
      check_read(chan_word(ch, 4'h9), {12'd0, pn, 16'd0}, "PN select");
    end
  endtask

  // Pulse on channel 2, then clear by writing 1
  task automatic sticky_channel_flag(input bit oos);
    logic [31:0] stat_bit;
    logic [31:0] summary_bit;
    stat_bit = oos ? 32'h4 : 32'h2;
    summary_bit = oos ? 32'h1 : 32'h2;
    @(posedge link_clk);
    if (oos) begin
      pn_oos <= 4'b0100;
    end else begin
      pn_err <= 4'b0100;
    end
    @(posedge link_clk);
    pn_err <= '0;
    pn_oos <= '0;
    for (int ch = 0; ch < n_ch; ch++) begin
      check_read(chan_word(ch, 4'h1), (ch == 2) ? stat_bit : 32'h0, "PN status");
    end
    check_read(10'h01A, summary_bit, "PN summary");
    axi_lite_write(word_to_byte(chan_word(2, 4'h1)), stat_bit);
    check_read(chan_word(2, 4'h1), 32'h0, "PN status after clear");
    check_read(10'h01A, 32'h0, "PN summary after clear");
  endtask

  task automatic sticky_pn_and_ovf();
    sticky_channel_flag(1'b0);
    sticky_channel_flag(1'b1);
    @(posedge link_clk);
    adc_dovf <= 1'b1;
    @(posedge link_clk);
    adc_dovf <= 1'b0;
    check_read(10'h021, 32'h1, "overflow");
    axi_lite_write(word_to_byte(10'h021), 32'h1);
    check_read(10'h021, 32'h0, "overflow after clear");
  endtask

  task automatic transport_profiles();
    logic [n_prof*8-1:0] m_v;
    logic [n_prof*8-1:0] l_v;
    logic [n_prof*8-1:0] s_v;
    logic [n_prof*8-1:0] f_v;
    logic [n_prof*8-1:0] n_v;
    logic [n_prof*8-1:0] np_v;
    m_v = $random(seed);
    l_v = $random(seed);
    s_v = $random(seed);
    f_v = $random(seed);
    n_v = $random(seed);
    np_v = $random(seed);
    @(posedge link_clk);
    jesd_m <= m_v;
    jesd_l <= l_v;
    jesd_s <= s_v;
    jesd_f <= f_v;
    jesd_n <= n_v;
    jesd_np <= np_v;
    check_read(10'h200, 32'd2, "profile count");
    for (int p = 0; p < n_prof; p++) begin
      check_read(10'h210 + 10'(2 * p),
                 {f_v[p*8 +: 8], s_v[p*8 +: 8], l_v[p*8 +: 8], m_v[p*8 +: 8]},
                 "profile word 0");
      check_read(10'h211 + 10'(2 * p), {16'd0, np_v[p*8 +: 8], n_v[p*8 +: 8]},
                 "profile word 1");
    end
    axi_lite_write(word_to_byte(10'h201), 32'd1);
    checks++;
    if (profile_sel !== 2'd1) begin
      errors++;
      $display("[ERROR] %0t: profile_sel is %0d, expected 1", $time, profile_sel);
    end
    // Out of range, must be ignored
    axi_lite_write(word_to_byte(10'h201), 32'd5);
    checks++;
    if (profile_sel !== 2'd1) begin
      errors++;
      $display("[ERROR] %0t: profile_sel is %0d after writing 5", $time, profile_sel);
    end
    check_read(10'h201, 32'd1, "profile select");
  endtask

  task automatic unmapped_access();
    last_resp = 2'b11;
    check_read(10'h3F0, 32'h0, "unmapped read");
    checks++;
    if (last_resp !== 2'b00) begin
      errors++;
      $display("[ERROR] %0t: unmapped read response %0d", $time, last_resp);
    end
    last_resp = 2'b11;
    axi_lite_write(word_to_byte(10'h3F0), $random(seed));
    checks++;
    if (last_resp !== 2'b00) begin
      errors++;
      $display("[ERROR] %0t: unmapped write response %0d", $time, last_resp);
    end
  endtask

  // ******************************************************************
  // Main sequence
  // ******************************************************************
  initial begin
    seed = 32'h7b11_1393;
    errors = 0;
    checks = 0;
    last_resp = 2'b00;
    adc_rst = 1'b1;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    pn_err = '0;
    pn_oos = '0;
    adc_dovf = 1'b0;
    jesd_m = '0;
    jesd_l = '0;
    jesd_s = '0;
    jesd_f = '0;
    jesd_n = '0;
    jesd_np = '0;
    repeat (10) @(posedge link_clk);
    adc_rst <= 1'b0;
    reset_and_identity();
    scratch_readback();
    channel_control();
    sticky_pn_and_ovf();
    transport_profiles();
    unmapped_access();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: tpl_adc_regmap.f
common/tpl_adc_pkg.sv
common/up_bus_if.sv
design/up_axi_slave.sv
regmap/up_adc_common.sv
regmap/up_adc_channel.sv
regmap/up_tpl_common.sv
regmap/tpl_adc_regmap.sv
+incdir+test
test/tb_tpl_adc_regmap.sv

// File: Bender.yml
package:
  name: tpl_adc_regmap

sources:
  - files:
      - common/tpl_adc_pkg.sv
      - common/up_bus_if.sv
      - design/up_axi_slave.sv
      - regmap/up_adc_common.sv
      - regmap/up_adc_channel.sv
      - regmap/up_tpl_common.sv
      - regmap/tpl_adc_regmap.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_tpl_adc_regmap.sv
